/* logic/roce_defs.svh */
`ifndef ROCE_DEFS_SVH
`define ROCE_DEFS_SVH

// Stream geometry
`define ROCE_DATA_W 64
`define ROCE_KEEP_W 8

// UDP ports
`define ROCE_LISTEN_PORT 16'h4321
`define ROCE_UDP_PORT 16'd4791
`define ROCE_SRC_PORT 16'd49152

// 22.1.212.10
`define ROCE_LOCAL_IP 32'h16_01_D4_0A

// BTH (12 bytes) plus RETH (16 bytes)
`define ROCE_HDR_BYTES 28
`define ROCE_OPCODE_WRITE_ONLY 8'h0A

// Largest single-packet DMA length, and the payload word counter width
`define ROCE_MAX_LEN 1024
`define ROCE_WORD_IDX_W 8

`endif

/* logic/roce_pkg.sv */
`include "roce_defs.svh"

package roce_pkg;

  // UDP header as seen on both the receive and the transmit side
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
  } udp_hdr_t;

  // One beat of a payload stream, lane 0 in the low bits
  typedef struct packed {
    logic [`ROCE_DATA_W-1:0] data;
    logic [`ROCE_KEEP_W-1:0] keep;
    logic                    last;
  } axis_word_t;

  // Transfer parameters parsed from the metadata datagram
  typedef struct packed {
    logic [31:0] dma_length;
    logic [31:0] r_key;
    logic [63:0] rem_addr;
    logic [23:0] rem_qpn;
    logic [23:0] rem_psn;
    logic [31:0] rem_ip;
  } conn_meta_t;

endpackage

/* logic/roce_frame_word.sv */
`timescale 1ns/100ps
`include "roce_defs.svh"

module roce_frame_word (
  input  roce_pkg::conn_meta_t         meta,
  input  logic [`ROCE_WORD_IDX_W-1:0]  word_idx,
  output roce_pkg::axis_word_t         beat
);
  import roce_pkg::*;

  // Index 27 holds payload byte 0
  logic [`ROCE_HDR_BYTES-1:0][7:0] hdr;
  logic [`ROCE_WORD_IDX_W+2:0]     byte_idx [`ROCE_KEEP_W];
  logic [`ROCE_WORD_IDX_W+2:0]     pay_idx  [`ROCE_KEEP_W];
  logic [31:0]                     total;

  // BTH then RETH
  assign hdr = {`ROCE_OPCODE_WRITE_ONLY, 8'h00, 16'hFFFF,
                8'h00, meta.rem_qpn,
                8'h00, meta.rem_psn,
                meta.rem_addr, meta.r_key, meta.dma_length};

  assign total = meta.dma_length + 32'(`ROCE_HDR_BYTES);

  always_comb begin
    beat = '0;
    for (int k = 0; k < `ROCE_KEEP_W; k++) begin
      byte_idx[k] = {word_idx, 3'(k)};
      pay_idx[k]  = byte_idx[k] - (`ROCE_WORD_IDX_W+3)'(`ROCE_HDR_BYTES);
      beat.keep[k] = (32'(byte_idx[k]) < total);
      if (!beat.keep[k]) begin
        beat.data[8*k +: 8] = 8'h00;
      end else if (byte_idx[k] < (`ROCE_WORD_IDX_W+3)'(`ROCE_HDR_BYTES)) begin
        beat.data[8*k +: 8] = hdr[5'(`ROCE_HDR_BYTES - 1) - byte_idx[k][4:0]];
      end else begin
        // Counting pattern wraps every 256 bytes
        beat.data[8*k +: 8] = pay_idx[k][7:0];
      end
    end
    // Last word once the next word would start past the frame
    beat.last = ((32'(word_idx) << 3) + 32'd8) >= total;
  end

endmodule

/* logic/roce_conn_mgr.sv */
`timescale 1ns/100ps
`include "roce_defs.svh"

module roce_conn_mgr (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rx_hdr_valid,
  output logic                 rx_hdr_ready,
  input  roce_pkg::udp_hdr_t   rx_hdr,
  input  logic                 rx_valid,
  output logic                 rx_ready,
  input  roce_pkg::axis_word_t rx_beat,
  output roce_pkg::conn_meta_t meta,
  output logic                 start
);
  import roce_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_CAPTURE, ST_DRAIN} state_t;

  state_t     state;
  logic [1:0] word_cnt;
  logic       check_q;
  logic       start_flag;
  logic       meta_ok;
  logic       hdr_fire;
  logic       beat_fire;
  conn_meta_t stage;

  assign rx_hdr_ready = (state == ST_IDLE);
  assign rx_ready     = (state != ST_IDLE);
  assign hdr_fire     = rx_hdr_valid && rx_hdr_ready;
  assign beat_fire    = rx_valid && rx_ready;

  // Needs all three words, the start flag and a length that fits one packet
  assign meta_ok = (word_cnt == 2'd3) && start_flag &&
                   (stage.dma_length != 32'd0) &&
                   (stage.dma_length <= 32'(`ROCE_MAX_LEN));

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      word_cnt <= 2'd0;
      check_q  <= 1'b0;
      start    <= 1'b0;
    end else begin
      start   <= check_q && meta_ok;
      check_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (hdr_fire) begin
            word_cnt <= 2'd0;
            // Port match decides the whole datagram
            state <= (rx_hdr.dst_port == `ROCE_LISTEN_PORT) ? ST_CAPTURE : ST_DRAIN;
          end
        end
        ST_CAPTURE: begin
          if (beat_fire) begin
            if (word_cnt != 2'd3) begin
              word_cnt <= word_cnt + 2'd1;
            end
            if (rx_beat.last) begin
              state   <= ST_IDLE;
              check_q <= 1'b1;
            end
          end
        end
        ST_DRAIN: begin
          if (beat_fire && rx_beat.last) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Field capture, multi-byte fields arrive big-endian
  always_ff @(posedge clk) begin
    if (hdr_fire) begin
      stage.rem_ip <= rx_hdr.src_ip;
    end
    if (beat_fire && state == ST_CAPTURE) begin
      case (word_cnt)
        2'd0: begin
          stage.dma_length <= {<<8{rx_beat.data[31:0]}};
          stage.r_key      <= {<<8{rx_beat.data[63:32]}};
        end
        2'd1: stage.rem_addr <= {<<8{rx_beat.data}};
        2'd2: begin
          stage.rem_qpn <= {<<8{rx_beat.data[23:0]}};
          stage.rem_psn <= {<<8{rx_beat.data[47:24]}};
          start_flag    <= rx_beat.data[48];
        end
        default: ;
      endcase
    end
    if (check_q && meta_ok) begin
      meta <= stage;
    end
  end

  a_start_single: assert property (@(posedge clk) disable iff (rst) start |=> !start);

endmodule

/* logic/roce_write_tx.sv */
`timescale 1ns/100ps
`include "roce_defs.svh"

module roce_write_tx (
  input  logic                 clk,
  input  logic                 rst,
  input  roce_pkg::conn_meta_t meta,
  input  logic                 start,
  output logic                 tx_hdr_valid,
  input  logic                 tx_hdr_ready,
  output roce_pkg::udp_hdr_t   tx_hdr,
  output logic                 tx_valid,
  input  logic                 tx_ready,
  output roce_pkg::axis_word_t tx_beat,
  output logic [7:0]           led
);
  import roce_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_PAY} state_t;

  state_t                      state;
  conn_meta_t                  meta_q;
  logic [`ROCE_WORD_IDX_W-1:0] word_idx;
  logic                        hdr_fire;
  logic                        beat_fire;

  roce_frame_word frame_word_inst (
    .meta     (meta_q),
    .word_idx (word_idx),
    .beat     (tx_beat)
  );

  assign tx_hdr_valid = (state == ST_HDR);
  assign tx_valid     = (state == ST_PAY);
  assign hdr_fire     = tx_hdr_valid && tx_hdr_ready;
  assign beat_fire    = tx_valid && tx_ready;

  // UDP length covers its own 8 bytes, BTH, RETH and the data
  always_comb begin
    tx_hdr.src_ip   = `ROCE_LOCAL_IP;
    tx_hdr.dst_ip   = meta_q.rem_ip;
    tx_hdr.src_port = `ROCE_SRC_PORT;
    tx_hdr.dst_port = `ROCE_UDP_PORT;
    tx_hdr.length   = meta_q.dma_length[15:0] + 16'(`ROCE_HDR_BYTES + 8);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      word_idx <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Start while busy is dropped
          if (start) begin
            state    <= ST_HDR;
            word_idx <= '0;
          end
        end
        ST_HDR: begin
          if (hdr_fire) begin
            state <= ST_PAY;
          end
        end
        ST_PAY: begin
          if (beat_fire) begin
            if (tx_beat.last) begin
              state <= ST_IDLE;
            end else begin
              word_idx <= word_idx + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      meta_q <= meta;
    end
  end

  // First payload byte of the latest frame
  always_ff @(posedge clk) begin
    if (rst) begin
      led <= 8'h00;
    end else if (beat_fire && word_idx == '0) begin
      led <= tx_beat.data[7:0];
    end
  end

  a_beat_hold: assert property (@(posedge clk) disable iff (rst)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat));

endmodule

/* logic/roce_udp_top.sv */
`timescale 1ns/100ps

module roce_udp_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rx_hdr_valid,
  output logic                 rx_hdr_ready,
  input  roce_pkg::udp_hdr_t   rx_hdr,
  input  logic                 rx_valid,
  output logic                 rx_ready,
  input  roce_pkg::axis_word_t rx_beat,
  output logic                 tx_hdr_valid,
  input  logic                 tx_hdr_ready,
  output roce_pkg::udp_hdr_t   tx_hdr,
  output logic                 tx_valid,
  input  logic                 tx_ready,
  output roce_pkg::axis_word_t tx_beat,
  output logic [7:0]           led
);
  import roce_pkg::*;

  conn_meta_t meta;
  logic       start;

  roce_conn_mgr conn_mgr_inst (
    .clk          (clk),
    .rst          (rst),
    .rx_hdr_valid (rx_hdr_valid),
    .rx_hdr_ready (rx_hdr_ready),
    .rx_hdr       (rx_hdr),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .rx_beat      (rx_beat),
    .meta         (meta),
    .start        (start)
  );

  roce_write_tx write_tx_inst (
    .clk          (clk),
    .rst          (rst),
    .meta         (meta),
    .start        (start),
    .tx_hdr_valid (tx_hdr_valid),
    .tx_hdr_ready (tx_hdr_ready),
    .tx_hdr       (tx_hdr),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .tx_beat      (tx_beat),
    .led          (led)
  );

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

endmodule

/* sim/roce_udp_tb.sv */
`timescale 1ns/100ps
`include "roce_defs.svh"

module roce_udp_tb;
  import roce_pkg::*;

  localparam int WAIT_LIMIT = 2000;

  typedef logic [7:0] byte_q_t[$];

  logic       clk;
  logic       rst;
  logic       rx_hdr_valid;
  logic       rx_hdr_ready;
  udp_hdr_t   rx_hdr;
  logic       rx_valid;
  logic       rx_ready;
  axis_word_t rx_beat;
  logic       tx_hdr_valid;
  logic       tx_hdr_ready;
  udp_hdr_t   tx_hdr;
  logic       tx_valid;
  logic       tx_ready;
  axis_word_t tx_beat;
  logic [7:0] led;

  tb_clk_gen clk_gen_inst (.clk(clk));

  roce_udp_top roce_udp_top_inst (.*);

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // One falling edge, then give up once the wait runs too long
  task automatic step(inout int cnt, input string what);
    @(negedge clk);
    cnt++;
    assert (cnt < WAIT_LIMIT) else begin
      $display("Timed out while %s", what);
      abort_run();
    end
  endtask

  // Most significant byte first
  function automatic byte_q_t be_bytes(input logic [63:0] v, input int n);
    byte_q_t q;
    for (int i = n - 1; i >= 0; i--) begin
      q.push_back(v[8*i +: 8]);
    end
    return q;
  endfunction

  task automatic send_datagram(input logic [15:0] port, input logic [31:0] src_ip,
                               input byte_q_t bytes);
    int cnt;
    int nwords;
    nwords = (bytes.size() + 7) / 8;
    rx_hdr = '{src_ip: src_ip, dst_ip: `ROCE_LOCAL_IP, src_port: 16'd5000,
               dst_port: port, length: 16'(8 + bytes.size())};
    rx_hdr_valid = 1'b1;
    cnt = 0;
    while (!rx_hdr_ready) step(cnt, "waiting for rx_hdr_ready");
    @(negedge clk);
    rx_hdr_valid = 1'b0;
    for (int w = 0; w < nwords; w++) begin
      rx_beat = '0;
      for (int k = 0; k < 8; k++) begin
        if (8*w + k < bytes.size()) begin
          rx_beat.data[8*k +: 8] = bytes[8*w + k];
          rx_beat.keep[k] = 1'b1;
        end
      end
      rx_beat.last = (w == nwords - 1);
      rx_valid = 1'b1;
      cnt = 0;
      while (!rx_ready) step(cnt, "waiting for rx_ready");
      @(negedge clk);
    end
    rx_valid = 1'b0;
    // Back to idle once the last beat is taken
    check_value("rx_ready", rx_ready, 1'b0);
  endtask

  // Metadata datagram with the start flag set, cut to nwords words
  task automatic send_meta(input logic [15:0] port, input logic [31:0] src_ip,
                           input logic [31:0] len, input logic [31:0] rkey,
                           input logic [63:0] addr, input logic [23:0] qpn,
                           input logic [23:0] psn, input int nwords);
    byte_q_t bytes;
    bytes = {be_bytes(len, 4), be_bytes(rkey, 4), be_bytes(addr, 8),
             be_bytes(qpn, 3), be_bytes(psn, 3), be_bytes(64'h0100, 2)};
    while (bytes.size() > 8 * nwords) void'(bytes.pop_back());
    send_datagram(port, src_ip, bytes);
  endtask

  task automatic expect_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      assert (!tx_hdr_valid && !tx_valid) else begin
        $display("Unexpected transmit output %0d cycles after the datagram", i);
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic collect_frame(input logic [31:0] rem_ip, input logic [31:0] len,
                               input logic [31:0] rkey, input logic [63:0] addr,
                               input logic [23:0] qpn, input logic [23:0] psn,
                               input bit random_ready);
    byte_q_t     exp_bytes;
    udp_hdr_t    exp_hdr;
    logic [63:0] exp_data;
    logic [63:0] mask;
    logic [7:0]  exp_keep;
    int          cnt;
    int          nwords;
    int          w;
    bit          done;
    // BTH with a zero pad ahead of QPN and PSN, then RETH, then the pattern
    exp_bytes = {be_bytes(`ROCE_OPCODE_WRITE_ONLY, 1), be_bytes(64'h00FFFF, 3),
                 be_bytes(qpn, 4), be_bytes(psn, 4), be_bytes(addr, 8),
                 be_bytes(rkey, 4), be_bytes(len, 4)};
    for (int i = 0; i < len; i++) begin
      exp_bytes.push_back(8'(i));
    end
    nwords = (exp_bytes.size() + 7) / 8;
    exp_hdr = '{src_ip: `ROCE_LOCAL_IP, dst_ip: rem_ip, src_port: `ROCE_SRC_PORT,
                dst_port: `ROCE_UDP_PORT, length: 16'(36 + len)};
    cnt = 0;
    done = 1'b0;
    while (!done) begin
      tx_hdr_ready = random_ready ? ($urandom % 3 != 0) : 1'b1;
      if (tx_hdr_valid && tx_hdr_ready) begin
        check_value("tx_hdr", tx_hdr, exp_hdr);
        done = 1'b1;
      end
      step(cnt, "waiting for the transmit header");
    end
    tx_hdr_ready = 1'b0;
    w = 0;
    cnt = 0;
    while (w < nwords) begin
      tx_ready = random_ready ? ($urandom % 3 != 0) : 1'b1;
      if (tx_valid && tx_ready) begin
        exp_data = '0;
        mask = '0;
        exp_keep = '0;
        for (int k = 0; k < 8; k++) begin
          if (8*w + k < exp_bytes.size()) begin
            exp_data[8*k +: 8] = exp_bytes[8*w + k];
            mask[8*k +: 8] = 8'hFF;
            exp_keep[k] = 1'b1;
          end
        end
        check_value("tx_beat.data", tx_beat.data & mask, exp_data);
        check_value("tx_beat.keep", tx_beat.keep, exp_keep);
        check_value("tx_beat.last", tx_beat.last, w == nwords - 1);
        w++;
      end
      step(cnt, "waiting for transmit payload beats");
    end
    tx_ready = 1'b0;
    check_value("tx_valid", tx_valid, 1'b0);
    check_value("led", led, `ROCE_OPCODE_WRITE_ONLY);
  endtask

  initial begin
    void'($urandom(27));
    rst = 1'b1;
    rx_hdr_valid = 1'b0;
    rx_hdr = '0;
    rx_valid = 1'b0;
    rx_beat = '0;
    tx_hdr_ready = 1'b0;
    tx_ready = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("tx_hdr_valid", tx_hdr_valid, 1'b0);
    check_value("tx_valid", tx_valid, 1'b0);
    check_value("led", led, 8'h00);
    check_value("rx_hdr_ready", rx_hdr_ready, 1'b1);
    check_value("rx_ready", rx_ready, 1'b0);
    // Plain single frame
    send_meta(`ROCE_LISTEN_PORT, 32'h0A00_0002, 32'd20, 32'h1BAD_F00D,
              64'h0000_0040_1234_5000, 24'h000011, 24'h000100, 3);
    collect_frame(32'h0A00_0002, 32'd20, 32'h1BAD_F00D, 64'h0000_0040_1234_5000,
                  24'h000011, 24'h000100, 1'b0);
    // Other port is drained
    send_meta(16'h1234, 32'h0A00_0003, 32'd20, 32'h1BAD_F00D,
              64'h0000_0040_1234_5000, 24'h000022, 24'h000200, 3);
    expect_quiet(200);
    check_value("rx_hdr_ready", rx_hdr_ready, 1'b1);
    // Short datagram and zero length, then a good one
    send_meta(`ROCE_LISTEN_PORT, 32'h0A00_0004, 32'd16, 32'h0000_1111,
              64'h0000_0000_0000_1000, 24'h000033, 24'h000300, 2);
    expect_quiet(100);
    send_meta(`ROCE_LISTEN_PORT, 32'h0A00_0005, 32'd0, 32'h0000_2222,
              64'h0000_0000_0000_2000, 24'h000044, 24'h000400, 3);
    expect_quiet(100);
    send_meta(`ROCE_LISTEN_PORT, 32'h0A00_0007, 32'd8, 32'h0000_7777,
              64'h0000_0000_DEAD_0000, 24'h0ABCDE, 24'h123456, 3);
    collect_frame(32'h0A00_0007, 32'd8, 32'h0000_7777, 64'h0000_0000_DEAD_0000,
                  24'h0ABCDE, 24'h123456, 1'b0);
    // Partial last word under random back-pressure
    send_meta(`ROCE_LISTEN_PORT, 32'h0A00_0009, 32'd61, 32'h5555_AAAA,
              64'hFEDC_BA98_7654_3210, 24'h000042, 24'hFFFFF0, 3);
    collect_frame(32'h0A00_0009, 32'd61, 32'h5555_AAAA, 64'hFEDC_BA98_7654_3210,
                  24'h000042, 24'hFFFFF0, 1'b1);
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* src.f */
+incdir+logic
logic/roce_pkg.sv
logic/roce_frame_word.sv
logic/roce_conn_mgr.sv
logic/roce_write_tx.sv
logic/roce_udp_top.sv
sim/tb_clk_gen.sv
sim/roce_udp_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module roce_udp_tb -f src.f -o roce_udp_sim \
  && ./obj_dir/roce_udp_sim | tee sim.log \
  || exit 1
grep -qx "Result: PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
